//--- flist.f
rtl/dram_pkg.sv
rtl/dram_req_if.sv
rtl/wb_req_decode.sv
rtl/dram_command.sv
rtl/read_return.sv
rtl/dram_ctrl_top.sv
tb/dram_model.sv
tb/dram_ctrl_props.sv
tb/dram_ctrl_tb.sv

//--- rtl/dram_command.sv
`timescale 1ns/1ps
`default_nettype none

module dram_command (
    input  logic                          CLK,
    input  logic                          nRST,
    dram_req_if.sequencer                 req,
    output dram_pkg::cmd_t                cmd,
    output logic                          reset_n,
    output logic                          cke,
    output logic [dram_pkg::BG_W-1:0]     bg,
    output logic [dram_pkg::BA_W-1:0]     ba,
    output dram_pkg::dram_addr_u          addr,
    output logic [dram_pkg::DATA_W-1:0]   dq_out,
    output logic                          dq_oe,
    output logic                          rd_issued,
    output logic                          wr_done
);

    // Mode-register loads in issue order, each entry is {bg, ba, value}
    localparam logic [dram_pkg::BG_W+dram_pkg::BA_W+dram_pkg::DRAM_ADDR_W-1:0]
        MR_TABLE [dram_pkg::MR_COUNT] = '{
            {2'd0, 2'd3, 17'h00000},   // MR3
            {2'd1, 2'd2, 17'h0080F},   // MR6
            {2'd1, 2'd1, 17'h00000},   // MR5
            {2'd1, 2'd0, 17'h01000},   // MR4
            {2'd0, 2'd2, 17'h00088},   // MR2
            {2'd0, 2'd1, 17'h00001},   // MR1
            {2'd0, 2'd0, 17'h0041D}    // MR0
        };

    enum logic [3:0] {
        ST_RESET, ST_CKE_LOW, ST_NOP, ST_MRS, ST_ZQC,
        ST_IDLE, ST_ACT, ST_RD, ST_WR, ST_PRE, ST_REF
    } state, n_state;

    logic [dram_pkg::CNT_W-1:0] cnt, limit;
    logic [dram_pkg::CNT_W-1:0] ref_cnt;
    logic [$clog2(dram_pkg::MR_COUNT)-1:0] mr_idx;
    logic ref_pending;
    logic done;
    logic first;
    logic in_service;

    assign done = (cnt == limit);
    assign first = (cnt == dram_pkg::CNT_W'(1)); // Commands go out on the first cycle only
    assign in_service = !(state inside {ST_RESET, ST_CKE_LOW, ST_NOP, ST_MRS, ST_ZQC});
    assign req.taken = (state == ST_IDLE) && !ref_pending && req.valid;
    assign dq_out = req.wdata;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= ST_RESET;
            cnt <= dram_pkg::CNT_W'(1);
            mr_idx <= '0;
        end else begin
            state <= n_state;
            cnt <= done ? dram_pkg::CNT_W'(1) : cnt + 1'b1;
            if (state == ST_MRS && done) begin
                mr_idx <= mr_idx + 1'b1;
            end
        end
    end

    // Free-running refresh interval once initialization is over
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            ref_cnt <= '0;
            ref_pending <= 1'b0;
        end else if (in_service) begin
            if (ref_cnt == dram_pkg::CNT_W'(dram_pkg::T_REFI - 1)) begin
                ref_cnt <= '0;
                ref_pending <= 1'b1;
            end else begin
                ref_cnt <= ref_cnt + 1'b1;
                if (state == ST_IDLE) begin
                    ref_pending <= 1'b0; // IDLE always leaves for REF when pending
                end
            end
        end
    end

    always_comb begin
        limit = dram_pkg::CNT_W'(1);
        case (state)
            ST_RESET, ST_CKE_LOW, ST_NOP: limit = dram_pkg::CNT_W'(dram_pkg::T_PWUP);
            ST_MRS: limit = dram_pkg::CNT_W'(dram_pkg::T_MOD);
            ST_ZQC: limit = dram_pkg::CNT_W'(dram_pkg::T_ZQINIT);
            ST_ACT: limit = dram_pkg::CNT_W'(dram_pkg::T_RCD);
            ST_RD:  limit = dram_pkg::CNT_W'(dram_pkg::T_CL + 1);
            ST_WR:  limit = dram_pkg::CNT_W'(dram_pkg::T_WR);
            ST_PRE: limit = dram_pkg::CNT_W'(dram_pkg::T_RP);
            ST_REF: limit = dram_pkg::CNT_W'(dram_pkg::T_RFC);
            default: ;
        endcase
    end

    always_comb begin
        n_state = state;
        case (state)
            ST_RESET:   if (done) n_state = ST_CKE_LOW;
            ST_CKE_LOW: if (done) n_state = ST_NOP;
            ST_NOP:     if (done) n_state = ST_MRS;
            ST_MRS: begin
                if (done && int'(mr_idx) == dram_pkg::MR_COUNT - 1) begin
                    n_state = ST_ZQC;
                end
            end
            ST_ZQC:     if (done) n_state = ST_IDLE;
            ST_IDLE: begin
                if (ref_pending) begin
                    n_state = ST_REF;
                end else if (req.valid) begin
                    n_state = ST_ACT;
                end
            end
            ST_ACT:     if (done) n_state = req.write ? ST_WR : ST_RD;
            ST_RD, ST_WR: if (done) n_state = ST_PRE;
            ST_PRE, ST_REF: if (done) n_state = ST_IDLE;
            default:    n_state = ST_RESET;
        endcase
    end

    always_comb begin
        cmd = dram_pkg::DESEL;
        reset_n = 1'b1;
        cke = 1'b1;
        bg = '0;
        ba = '0;
        addr = '0;
        dq_oe = 1'b0;
        rd_issued = 1'b0;
        wr_done = 1'b0;

        case (state)
            ST_RESET: begin
                reset_n = 1'b0;
                cke = 1'b0;
            end
            ST_CKE_LOW: cke = 1'b0;
            ST_NOP:     cmd = dram_pkg::NOP;
            ST_MRS: begin
                if (first) begin
                    cmd = dram_pkg::MRS;
                    {bg, ba, addr.row} = MR_TABLE[mr_idx];
                end
            end
            ST_ZQC: begin
                if (first) begin
                    cmd = dram_pkg::ZQC;
                    addr.row = 17'h00400; // A10 high selects the long calibration
                end
            end
            ST_ACT: begin
                if (first) begin
                    cmd = dram_pkg::ACT;
                    bg = req.bg;
                    ba = req.ba;
                    addr.row = dram_pkg::DRAM_ADDR_W'(req.row);
                end
            end
            ST_RD, ST_WR: begin
                if (first) begin
                    cmd = (state == ST_WR) ? dram_pkg::WR : dram_pkg::RD;
                    bg = req.bg;
                    ba = req.ba;
                    addr.col.ap = 1'b0;
                    addr.col.column = req.col;
                    dq_oe = (state == ST_WR);
                    rd_issued = (state == ST_RD);
                end
            end
            ST_PRE: begin
                if (first) begin
                    cmd = dram_pkg::PRE;
                    bg = req.bg;
                    ba = req.ba;
                    wr_done = req.write;
                end
            end
            ST_REF:     if (first) cmd = dram_pkg::REF;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/dram_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module dram_ctrl_top (
    input  logic                                CLK,
    input  logic                                nRST,
    // Wishbone classic slave
    input  logic                                cyc,
    input  logic                                stb,
    input  logic                                we,
    input  logic [dram_pkg::ADR_W-1:0]          adr,
    input  logic [dram_pkg::DATA_W-1:0]         dat_w,
    output logic [dram_pkg::DATA_W-1:0]         dat_r,
    output logic                                ack,
    // DRAM pins
    output logic                                reset_n,
    output logic                                cke,
    output logic                                cs_n,
    output logic                                act_n,
    output logic                                ras_n_a16,
    output logic                                cas_n_a15,
    output logic                                we_n_a14,
    output logic [dram_pkg::BG_W-1:0]           bg,
    output logic [dram_pkg::BA_W-1:0]           ba,
    output logic [dram_pkg::DRAM_ADDR_W-1:0]    addr,
    output logic [dram_pkg::DATA_W-1:0]         dq_out,
    output logic                                dq_oe,
    input  logic [dram_pkg::DATA_W-1:0]         dq_in
);

    dram_pkg::cmd_t       cmd;
    dram_pkg::dram_addr_u addr_u;
    logic                 rd_issued;
    logic                 wr_done;

    dram_req_if req_bus ();

    wb_req_decode i_decode (
        .CLK(CLK), .nRST(nRST),
        .cyc(cyc), .stb(stb), .we(we), .adr(adr), .dat_w(dat_w), .ack(ack),
        .req(req_bus)
    );

    dram_command i_command (
        .CLK(CLK), .nRST(nRST), .req(req_bus),
        .cmd(cmd), .reset_n(reset_n), .cke(cke), .bg(bg), .ba(ba), .addr(addr_u),
        .dq_out(dq_out), .dq_oe(dq_oe), .rd_issued(rd_issued), .wr_done(wr_done)
    );

    read_return i_return (
        .CLK(CLK), .nRST(nRST), .rd_issued(rd_issued), .wr_done(wr_done),
        .dq_in(dq_in), .dat_r(dat_r), .ack(ack)
    );

    assign {cs_n, act_n, ras_n_a16, cas_n_a15, we_n_a14} = cmd;
    assign addr = addr_u;

endmodule

`default_nettype wire

//--- rtl/dram_pkg.sv
`default_nettype none

package dram_pkg;

    // Data and address map
    localparam int DATA_W = 32;
    localparam int COL_W = 10;
    localparam int BA_W = 2;
    localparam int BG_W = 2;
    localparam int ROW_W = 14;
    localparam int ADR_W = ROW_W + BG_W + BA_W + COL_W; // Wishbone word address
    localparam int DRAM_ADDR_W = 17;                    // A16..A0 on the pins

    // Width of the sequencer's timing and refresh counters
    localparam int CNT_W = 8;

    // Timing in controller clocks, scaled down for simulation
    localparam int T_PWUP = 20;
    localparam int T_MOD = 4;
    localparam int T_ZQINIT = 8;
    localparam int T_RCD = 3;
    localparam int T_RP = 3;
    localparam int T_CL = 5;
    localparam int T_WR = 4;
    localparam int T_RFC = 10;
    localparam int T_REFI = 200;

    localparam int MR_COUNT = 7; // MR0 to MR6

    // {cs_n, act_n, ras_n_a16, cas_n_a15, we_n_a14}
    typedef enum logic [4:0] {
        DESEL = 5'b11111,
        NOP   = 5'b01111,
        ACT   = 5'b00000, // Upper row bits are zero with a 14-bit row
        RD    = 5'b01101,
        WR    = 5'b01100,
        PRE   = 5'b01010,
        REF   = 5'b01001,
        MRS   = 5'b01000,
        ZQC   = 5'b01110
    } cmd_t;

    // One address word, read as a row for ACT and as a column for RD and WR
    typedef union packed {
        logic [DRAM_ADDR_W-1:0] row;
        struct packed {
            logic [DRAM_ADDR_W-COL_W-2:0] spare;
            logic                         ap;     // A10 auto-precharge
            logic [COL_W-1:0]             column;
        } col;
    } dram_addr_u;

endpackage

`default_nettype wire

//--- rtl/dram_req_if.sv
`timescale 1ns/1ps
`default_nettype none

interface dram_req_if;

    logic                          valid;
    logic                          write;
    logic [dram_pkg::BG_W-1:0]     bg;
    logic [dram_pkg::BA_W-1:0]     ba;
    logic [dram_pkg::ROW_W-1:0]    row;
    logic [dram_pkg::COL_W-1:0]    col;
    logic [dram_pkg::DATA_W-1:0]   wdata;
    logic                          taken; // Sequencer has accepted the request

    modport decoder (
        output valid, write, bg, ba, row, col, wdata,
        input  taken
    );

    modport sequencer (
        input  valid, write, bg, ba, row, col, wdata,
        output taken
    );

endinterface

`default_nettype wire

//--- rtl/read_return.sv
`timescale 1ns/1ps
`default_nettype none

module read_return (
    input  logic                          CLK,
    input  logic                          nRST,
    input  logic                          rd_issued,
    input  logic                          wr_done,
    input  logic [dram_pkg::DATA_W-1:0]   dq_in,
    output logic [dram_pkg::DATA_W-1:0]   dat_r,
    output logic                          ack
);

    // Bit k is set k+1 cycles after a READ left the sequencer
    logic [dram_pkg::T_CL-1:0] lat_sr;
    logic                      rd_arrive;

    assign rd_arrive = lat_sr[dram_pkg::T_CL-1]; // Read data is on dq_in now

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            lat_sr <= '0;
            ack <= 1'b0;
        end else begin
            lat_sr <= {lat_sr[dram_pkg::T_CL-2:0], rd_issued};
            ack <= rd_arrive || wr_done;
        end
    end

    always_ff @(posedge CLK) begin
        if (rd_arrive) begin
            dat_r <= dq_in; // Held until the next read returns
        end
    end

endmodule

`default_nettype wire

//--- rtl/wb_req_decode.sv
`timescale 1ns/1ps
`default_nettype none

module wb_req_decode (
    input  logic                          CLK,
    input  logic                          nRST,
    input  logic                          cyc,
    input  logic                          stb,
    input  logic                          we,
    input  logic [dram_pkg::ADR_W-1:0]    adr,
    input  logic [dram_pkg::DATA_W-1:0]   dat_w,
    input  logic                          ack,
    dram_req_if.decoder                   req
);

    // Bit positions of the fields in the word address
    localparam int BA_LSB = dram_pkg::COL_W;
    localparam int BG_LSB = BA_LSB + dram_pkg::BA_W;
    localparam int ROW_LSB = BG_LSB + dram_pkg::BG_W;

    logic pending; // A Wishbone cycle is latched and not yet acknowledged
    logic accept;

    assign accept = cyc && stb && !pending;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            pending <= 1'b0;
            req.valid <= 1'b0;
        end else begin
            if (accept) begin
                pending <= 1'b1;
                req.valid <= 1'b1;
            end else begin
                if (req.taken) begin
                    req.valid <= 1'b0;
                end
                if (ack) begin
                    pending <= 1'b0; // The master drops stb after this ack
                end
            end
        end
    end

    // Request payload stays put until the next accepted cycle
    always_ff @(posedge CLK) begin
        if (accept) begin
            req.write <= we;
            req.col <= adr[dram_pkg::COL_W-1:0];
            req.ba <= adr[BA_LSB +: dram_pkg::BA_W];
            req.bg <= adr[BG_LSB +: dram_pkg::BG_W];
            req.row <= adr[ROW_LSB +: dram_pkg::ROW_W];
            req.wdata <= dat_w;
        end
    end

endmodule

`default_nettype wire

//--- tb/dram_ctrl_props.sv
`timescale 1ns/1ps
`default_nettype none

module dram_ctrl_props (
    input logic CLK,
    input logic nRST,
    input logic cke,
    input logic cs_n,
    input logic act_n,
    input logic ras_n_a16,
    input logic cas_n_a15,
    input logic we_n_a14,
    input logic cyc,
    input logic stb,
    input logic ack
);

    logic [4:0] cmd;
    int n_fail = 0;

    assign cmd = {cs_n, act_n, ras_n_a16, cas_n_a15, we_n_a14};

    a_cmd_needs_cke: assert property (@(posedge CLK) disable iff (!nRST)
        cmd != dram_pkg::DESEL |-> cke)
        else begin n_fail++; $error("command driven while cke is low"); end

    // The access command may come no earlier than T_RCD cycles after ACT
    a_rcd: assert property (@(posedge CLK) disable iff (!nRST)
        cmd == dram_pkg::ACT |=> (cmd != dram_pkg::RD && cmd != dram_pkg::WR) [*dram_pkg::T_RCD-1])
        else begin n_fail++; $error("RD or WR too soon after ACT"); end

    a_rp: assert property (@(posedge CLK) disable iff (!nRST)
        cmd == dram_pkg::PRE |=> (cmd != dram_pkg::ACT) [*dram_pkg::T_RP-1])
        else begin n_fail++; $error("ACT too soon after PRE"); end

    a_rfc: assert property (@(posedge CLK) disable iff (!nRST)
        cmd == dram_pkg::REF |=> (cmd != dram_pkg::ACT) [*dram_pkg::T_RFC-1])
        else begin n_fail++; $error("ACT too soon after REF"); end

    a_ack_in_cycle: assert property (@(posedge CLK) disable iff (!nRST)
        ack |-> cyc && stb)
        else begin n_fail++; $error("ack outside a Wishbone cycle"); end

endmodule

bind dram_ctrl_top dram_ctrl_props i_props (
    .CLK(CLK), .nRST(nRST), .cke(cke),
    .cs_n(cs_n), .act_n(act_n), .ras_n_a16(ras_n_a16), .cas_n_a15(cas_n_a15),
    .we_n_a14(we_n_a14), .cyc(cyc), .stb(stb), .ack(ack)
);

`default_nettype wire

//--- tb/dram_ctrl_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dram_ctrl_tb;

    localparam int ACK_TIMEOUT = 400;

    logic CLK;
    logic nRST;
    logic cyc;
    logic stb;
    logic we;
    logic [dram_pkg::ADR_W-1:0]       adr;
    logic [dram_pkg::DATA_W-1:0]      dat_w;
    logic [dram_pkg::DATA_W-1:0]      dat_r;
    logic                             ack;
    logic                             reset_n;
    logic                             cke;
    logic                             cs_n;
    logic                             act_n;
    logic                             ras_n_a16;
    logic                             cas_n_a15;
    logic                             we_n_a14;
    logic [dram_pkg::BG_W-1:0]        bg;
    logic [dram_pkg::BA_W-1:0]        ba;
    logic [dram_pkg::DRAM_ADDR_W-1:0] addr;
    logic [dram_pkg::DATA_W-1:0]      dq_out;
    logic                             dq_oe;
    logic [dram_pkg::DATA_W-1:0]      dq_in;

    // Stimulus table, one Wishbone cycle per entry
    string                       step_name [$];
    logic                        step_we [$];
    logic [dram_pkg::ADR_W-1:0]  step_adr [$];
    logic [dram_pkg::DATA_W-1:0] step_dat [$];

    logic [dram_pkg::DATA_W-1:0] scoreboard [logic [dram_pkg::ADR_W-1:0]];
    int n_acks = 0;
    int n_cycles = 0;

    dram_ctrl_top i_dut (.*);

    dram_model i_model (
        .CLK(CLK), .reset_n(reset_n), .cke(cke), .cs_n(cs_n), .act_n(act_n),
        .ras_n_a16(ras_n_a16), .cas_n_a15(cas_n_a15), .we_n_a14(we_n_a14),
        .bg(bg), .ba(ba), .addr(addr), .dq_out(dq_out), .dq_oe(dq_oe), .dq_in(dq_in)
    );

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    always @(posedge CLK) begin
        if (ack) n_acks <= n_acks + 1; // Counts pulses, one per high cycle
    end

    always @(negedge CLK) begin
        if (i_dut.i_props.n_fail != 0) stop_on_error("a protocol assertion failed");
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            stop_on_error($sformatf("mismatch %s expected %h actual %h", name, expected, actual));
        end
    endtask

    function automatic logic [dram_pkg::ADR_W-1:0] make_adr(input logic [13:0] row,
            input logic [1:0] g, input logic [1:0] b, input logic [9:0] col);
        return {row, g, b, col};
    endfunction

    task automatic add_step(input string name, input logic wr,
                            input logic [dram_pkg::ADR_W-1:0] a, input logic [31:0] d);
        step_name.push_back(name);
        step_we.push_back(wr);
        step_adr.push_back(a);
        step_dat.push_back(d);
    endtask

    task automatic build_table();
        logic [13:0] r0;
        logic [13:0] r1;
        logic [13:0] r2;
        logic [13:0] r3;
        r0 = 14'($urandom());
        r1 = 14'($urandom());
        r2 = 14'($urandom());
        r3 = 14'($urandom());
        add_step("wr_during_init", 1'b1, make_adr(r0, 2'd0, 2'd0, 10'h005), 32'hA5A5_0001);
        add_step("rd_after_wr", 1'b0, make_adr(r0, 2'd0, 2'd0, 10'h005), '0);
        add_step("rd_unwritten", 1'b0, make_adr(~r0, 2'd2, 2'd2, 10'h001), '0);
        add_step("wr_bg1_ba2", 1'b1, make_adr(r1, 2'd1, 2'd2, 10'h3FF), 32'h1111_2222);
        add_step("wr_bg2_ba1", 1'b1, make_adr(r2, 2'd2, 2'd1, 10'h100), 32'h3333_4444);
        add_step("rd_bg1_ba2", 1'b0, make_adr(r1, 2'd1, 2'd2, 10'h3FF), '0);
        add_step("wr_bg3_ba3", 1'b1, make_adr(r3, 2'd3, 2'd3, 10'h07A), 32'h5555_6666);
        add_step("rd_bg2_ba1", 1'b0, make_adr(r2, 2'd2, 2'd1, 10'h100), '0);
        add_step("rd_bg3_ba3", 1'b0, make_adr(r3, 2'd3, 2'd3, 10'h07A), '0);
        add_step("wr_overwrite", 1'b1, make_adr(r0, 2'd0, 2'd0, 10'h005), 32'hDEAD_BEEF);
        add_step("rd_overwrite", 1'b0, make_adr(r0, 2'd0, 2'd0, 10'h005), '0);
    endtask

    task automatic wait_ack(input string name);
        int n;
        n = 0;
        while (ack !== 1'b1) begin
            if (n == ACK_TIMEOUT) begin
                stop_on_error($sformatf("ack for %s never came within %0d cycles",
                                        name, ACK_TIMEOUT));
            end
            @(negedge CLK);
            n++;
        end
    endtask

    task automatic do_access(input string name, input logic wr,
                             input logic [dram_pkg::ADR_W-1:0] a, input logic [31:0] d);
        int acks_before;
        logic [31:0] expected;
        @(negedge CLK);
        acks_before = n_acks;
        cyc = 1'b1;
        stb = 1'b1;
        we = wr;
        adr = a;
        dat_w = d;
        wait_ack(name);
        n_cycles++;
        if (wr) begin
            scoreboard[a] = d;
        end else begin
            expected = scoreboard.exists(a) ? scoreboard[a] : '0;
            check_value(name, expected, dat_r);
        end
        check_value({name, " dram address"}, 32'(a), 32'(i_model.last_key));
        @(negedge CLK); // The master holds the cycle through the edge that samples ack
        cyc = 1'b0;
        stb = 1'b0;
        @(negedge CLK);
        check_value({name, " ack pulses"}, 32'd1, 32'(n_acks - acks_before));
    endtask

    task automatic check_init();
        check_value("init reset_n rises before cke", 32'd1,
                    32'(i_model.rst_rise_cyc >= 0 && i_model.rst_rise_cyc < i_model.cke_rise_cyc));
        check_value("init cke rises before mrs", 32'd1,
                    32'(i_model.cke_rise_cyc < i_model.first_mrs_cyc));
        check_value("init mrs count", dram_pkg::MR_COUNT, i_model.mrs_at_act);
        check_value("init zqc before act", 32'd1, i_model.zqc_at_act);
        check_value("init zqc before first ack", 32'd1, i_model.n_zqc);
    endtask

    initial begin
        int refs_before;
        void'($urandom(57));
        nRST = 1'b0;
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
        adr = '0;
        dat_w = '0;
        build_table();
        repeat (16) @(negedge CLK);
        nRST = 1'b1;
        check_value("request during reset", 32'd0, 32'(reset_n));

        for (int i = 0; i < step_name.size(); i++) begin
            do_access(step_name[i], step_we[i], step_adr[i], step_dat[i]);
            if (i == 0) check_init();
        end

        // Idle long enough for the refresh interval to expire
        refs_before = i_model.n_ref;
        repeat (dram_pkg::T_REFI + 20) @(negedge CLK);
        check_value("refresh during idle gap", 32'd1, 32'(i_model.n_ref > refs_before));
        foreach (scoreboard[a]) begin
            do_access($sformatf("rd_after_refresh_%h", a), 1'b0, a, '0);
        end

        check_value("total ack pulses", n_cycles, n_acks);
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/dram_model.sv
`timescale 1ns/1ps
`default_nettype none

module dram_model (
    input  logic                                CLK,
    input  logic                                reset_n,
    input  logic                                cke,
    input  logic                                cs_n,
    input  logic                                act_n,
    input  logic                                ras_n_a16,
    input  logic                                cas_n_a15,
    input  logic                                we_n_a14,
    input  logic [dram_pkg::BG_W-1:0]           bg,
    input  logic [dram_pkg::BA_W-1:0]           ba,
    input  logic [dram_pkg::DRAM_ADDR_W-1:0]    addr,
    input  logic [dram_pkg::DATA_W-1:0]         dq_out,
    input  logic                                dq_oe,
    output logic [dram_pkg::DATA_W-1:0]         dq_in
);

    logic [4:0]                  cmd;
    logic [dram_pkg::ADR_W-1:0]  key;
    logic [dram_pkg::DATA_W-1:0] mem [logic [dram_pkg::ADR_W-1:0]]; // Sparse, absent means zero
    logic [dram_pkg::ROW_W-1:0]  open_row [16] = '{default: '0};
    logic [dram_pkg::DATA_W-1:0] rd_pipe [dram_pkg::T_CL] = '{default: '0};
    logic [dram_pkg::ADR_W-1:0]  last_key = '0; // Word address of the last RD or WR
    logic prev_reset_n = 1'b0;
    logic prev_cke = 1'b0;
    int cycle = 0;
    int rst_rise_cyc = -1;
    int cke_rise_cyc = -1;
    int first_mrs_cyc = -1;
    int n_mrs = 0;
    int n_zqc = 0;
    int n_ref = 0;
    int n_act = 0;
    int mrs_at_act = -1;
    int zqc_at_act = -1;

    assign cmd = {cs_n, act_n, ras_n_a16, cas_n_a15, we_n_a14};
    assign key = {open_row[{bg, ba}], bg, ba, addr[dram_pkg::COL_W-1:0]};
    assign dq_in = rd_pipe[dram_pkg::T_CL-1];

    always @(posedge CLK) begin
        cycle++;
        if (reset_n && !prev_reset_n && rst_rise_cyc < 0) rst_rise_cyc = cycle;
        if (cke && !prev_cke && cke_rise_cyc < 0) cke_rise_cyc = cycle;
        prev_reset_n = reset_n;
        prev_cke = cke;

        for (int i = dram_pkg::T_CL - 1; i > 0; i--) begin
            rd_pipe[i] <= rd_pipe[i-1];
        end
        rd_pipe[0] <= '0;

        if (cke) begin
            case (cmd)
                dram_pkg::MRS: begin
                    if (first_mrs_cyc < 0) first_mrs_cyc = cycle;
                    n_mrs++;
                end
                dram_pkg::ZQC: n_zqc++;
                dram_pkg::REF: n_ref++;
                dram_pkg::ACT: begin
                    if (n_act == 0) begin
                        mrs_at_act = n_mrs; // Snapshot of the init sequence
                        zqc_at_act = n_zqc;
                    end
                    n_act++;
                    open_row[{bg, ba}] = addr[dram_pkg::ROW_W-1:0];
                end
                dram_pkg::WR: begin
                    last_key = key;
                    if (dq_oe) mem[key] = dq_out;
                end
                dram_pkg::RD: begin
                    last_key = key;
                    rd_pipe[0] <= mem.exists(key) ? mem[key] : '0;
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire
